// ==== build.f ====
+incdir+include
hw/bp_pkg.sv
hw/bp_update_if.sv
hw/direct_mapped_table.sv
hw/branch_target_buffer.sv
hw/direction_predictor.sv
hw/next_fetch_select.sv
hw/branch_predictor_top.sv
tb/tb_clock_gen.sv
tb/bp_checker.sv
tb/bp_assertions.sv
tb/branch_predictor_tb.sv

// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := branch_predictor_tb
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "*** PASSED ***" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/branch_predictor_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

// Testbench top for the branch predictor.
module branch_predictor_tb;

  localparam bp_pkg::addr_t idle_addr = 32'h0000_1000;
  // Trained branch, an alias on the same index, and a second branch.
  localparam bp_pkg::addr_t addr_a    = 32'h0001_2340;
  localparam bp_pkg::addr_t target_a  = 32'h0000_8000;
  localparam bp_pkg::addr_t addr_a2   = 32'h0004_5640;
  localparam bp_pkg::addr_t addr_b    = 32'h0000_7780;
  localparam bp_pkg::addr_t target_b  = 32'h0000_9100;

  logic          clk;
  logic          reset;
  bp_pkg::addr_t fetch_addr;
  logic          update;
  bp_pkg::addr_t update_addr;
  bp_pkg::addr_t actual_target;
  logic          branch_taken;
  logic          predict_taken;
  logic          btb_hit;
  bp_pkg::addr_t next_pc;
  string         test_name;
  int            mismatches;
  int            compares;
  int            timeouts;

  tb_clock_gen u_clock (.clk(clk), .reset(reset));

  branch_predictor_top dut (
    .clk(clk), .reset(reset), .fetch_addr(fetch_addr),
    .update(update), .update_addr(update_addr), .actual_target(actual_target),
    .branch_taken(branch_taken), .predict_taken(predict_taken),
    .btb_hit(btb_hit), .next_pc(next_pc)
  );

  bp_checker u_checker (
    .clk(clk), .reset(reset), .fetch_addr(fetch_addr),
    .update(update), .update_addr(update_addr), .actual_target(actual_target),
    .branch_taken(branch_taken), .predict_taken(predict_taken),
    .btb_hit(btb_hit), .next_pc(next_pc), .test_name(test_name),
    .mismatches(mismatches), .compares(compares)
  );

  // One cycle of inputs, applied 1 ns after the rising edge.
  task automatic step(input bp_pkg::addr_t f, input logic u, input bp_pkg::addr_t ua,
                      input bp_pkg::addr_t ut, input logic tk);
    fetch_addr    = f;
    update        = u;
    update_addr   = ua;
    actual_target = ut;
    branch_taken  = tk;
    @(posedge clk);
    #1;
  endtask

  task automatic lookup(input bp_pkg::addr_t f);
    step(f, 1'b0, '0, '0, 1'b0);
  endtask

  task automatic resolve(input bp_pkg::addr_t a, input bp_pkg::addr_t t, input logic tk);
    step(idle_addr, 1'b1, a, t, tk);
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (reset && n < 20);
    if (reset) begin
      timeouts++;
      $display("Timeout: reset was still high after %0d cycles", n);
    end
    @(posedge clk);
    #1;
  endtask

  // Idle until the lookups in flight have been compared.
  task automatic drain();
    int target_count;
    int n;
    target_count = compares + 3;
    n = 0;
    while (compares < target_count && n < 10) begin
      lookup(idle_addr);
      n++;
    end
    if (compares < target_count) begin
      timeouts++;
      $display("Timeout: checker stopped comparing outputs during %s", test_name);
    end
  endtask

  // Small pool, so indices collide and tags alias.
  function automatic bp_pkg::addr_t pool_addr();
    bp_pkg::addr_t a;
    a = ($urandom % 3) << 8;
    a = a | (($urandom % 4) << 2);
    return a;
  endfunction

  initial begin
    timeouts = 0;
    test_name = "reset_state";
    fetch_addr = '0;
    update = 1'b0;
    update_addr = '0;
    actual_target = '0;
    branch_taken = 1'b0;
    void'($urandom(57));
    wait_reset_release();
    repeat (20) lookup($urandom & 32'hffff_fffc);
    drain();
    test_name = "train_taken";
    resolve(addr_a, target_a, 1'b1);
    resolve(addr_a, target_a, 1'b1);
    lookup(addr_a);
    drain();
    test_name = "not_taken_invalidate";
    resolve(addr_a, target_a, 1'b0);
    lookup(addr_a);
    drain();
    test_name = "alias_tag";
    resolve(addr_a, target_a, 1'b1);
    lookup(addr_a2);
    lookup(addr_a);
    drain();
    test_name = "same_edge_update";
    step(addr_b, 1'b1, addr_b, target_b, 1'b1);
    lookup(addr_b);
    drain();
    test_name = "random_mix";
    for (int i = 0; i < 2000; i++) begin
      step(pool_addr(), 1'($urandom % 2), pool_addr(), $urandom & 32'hffff_fffc,
           ($urandom % 10) < 6);
    end
    drain();
    $display("Closing: %0d mismatches, %0d timeouts, %0d compares",
             mismatches, timeouts, compares);
    if (mismatches == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/bp_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

// Protocol checks on the predictor outputs.
module bp_assertions (
  input wire logic          clk,
  input wire logic          reset,
  input wire logic          predict_taken,
  input wire logic          btb_hit,
  input wire bp_pkg::addr_t next_pc
);

  // A reset edge leaves all outputs at zero.
  reset_clears_outputs: assert property (@(posedge clk)
    reset |=> (!predict_taken && !btb_hit && next_pc == '0))
    else $error("outputs not cleared after a reset edge");

  // A taken prediction needs a BTB hit for its target.
  taken_needs_hit: assert property (@(posedge clk) disable iff (reset)
    predict_taken |-> btb_hit)
    else $error("predict_taken high without btb_hit");

endmodule

bind branch_predictor_top bp_assertions u_assertions (
  .clk           (clk),
  .reset         (reset),
  .predict_taken (predict_taken),
  .btb_hit       (btb_hit),
  .next_pc       (next_pc)
);

`default_nettype wire

// ==== tb/bp_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_macros.svh"

// Reference model of the predictor and output comparator.
module bp_checker (
  input  wire logic          clk,
  input  wire logic          reset,
  input  wire bp_pkg::addr_t fetch_addr,
  input  wire logic          update,
  input  wire bp_pkg::addr_t update_addr,
  input  wire bp_pkg::addr_t actual_target,
  input  wire logic          branch_taken,
  input  wire logic          predict_taken,
  input  wire logic          btb_hit,
  input  wire bp_pkg::addr_t next_pc,
  input  string              test_name,
  output int                 mismatches,
  output int                 compares
);

  localparam int entries = 1 << `BP_INDEX_BITS;

  // Model storage.
  logic          model_valid  [entries];
  bp_pkg::tag_t  model_tag    [entries];
  bp_pkg::addr_t model_target [entries];
  bp_pkg::ctr_t  model_ctr    [entries];

  // Lookup taken at the last edge, one stage from the outputs.
  logic          lk_hit;
  logic          lk_taken;
  bp_pkg::addr_t lk_pc;
  // Values the outputs must hold now.
  logic          exp_ok;
  logic          exp_hit;
  logic          exp_taken;
  bp_pkg::addr_t exp_pc;

  bp_pkg::index_t idx;
  bp_pkg::index_t uidx;

  initial begin
    mismatches = 0;
    compares   = 0;
    exp_ok     = 1'b0;
  end

  task automatic report_mismatch(input string what, input bp_pkg::addr_t exp_value,
                                 input bp_pkg::addr_t act_value);
    mismatches++;
    $display("Mismatch %s %s: expected %h actual %h", test_name, what, exp_value, act_value);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < entries; i++) begin
        model_valid[i]  = 1'b0;
        model_tag[i]    = '0;
        model_target[i] = '0;
        model_ctr[i]    = `BP_CTR_RESET;
      end
      // Outputs are cleared by the reset edge itself.
      exp_ok    = 1'b1;
      exp_hit   = 1'b0;
      exp_taken = 1'b0;
      exp_pc    = '0;
      // Tables read as empty, the delayed address still moves.
      lk_hit    = 1'b0;
      lk_taken  = 1'b0;
      lk_pc     = fetch_addr + 32'd4;
    end else begin
      exp_hit   = lk_hit;
      exp_taken = lk_taken;
      exp_pc    = lk_pc;
      // Lookup first, so it sees storage from before this edge.
      idx      = fetch_addr[`BP_INDEX_BITS-1:0];
      lk_hit   = model_valid[idx] &&
                 (model_tag[idx] == fetch_addr[`BP_ADDR_BITS-1:`BP_INDEX_BITS]);
      lk_taken = lk_hit && model_ctr[idx][1];
      lk_pc    = lk_taken ? model_target[idx] : fetch_addr + 32'd4;
      // Then the resolved branch.
      if (update) begin
        uidx = update_addr[`BP_INDEX_BITS-1:0];
        if (branch_taken) begin
          model_valid[uidx]  = 1'b1;
          model_tag[uidx]    = update_addr[`BP_ADDR_BITS-1:`BP_INDEX_BITS];
          model_target[uidx] = actual_target;
          if (model_ctr[uidx] != 2'b11) model_ctr[uidx] = model_ctr[uidx] + 2'd1;
        end else begin
          model_valid[uidx] = 1'b0;
          if (model_ctr[uidx] != 2'b00) model_ctr[uidx] = model_ctr[uidx] - 2'd1;
        end
      end
    end
  end

  // Outputs are settled half a cycle after the edge.
  always @(negedge clk) begin
    if (exp_ok) begin
      compares++;
      if (predict_taken !== exp_taken) report_mismatch("predict_taken", 32'(exp_taken),
                                                       32'(predict_taken));
      if (btb_hit !== exp_hit) report_mismatch("btb_hit", 32'(exp_hit), 32'(btb_hit));
      if (next_pc !== exp_pc) report_mismatch("next_pc", exp_pc, next_pc);
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

// Free running clock and a synchronous reset pulse.
module tb_clock_gen #(
  parameter int half_period  = 5,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // Reset covers the first rising edges, released just after the last one.
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== hw/branch_predictor_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// Fetch-stage branch predictor.
// Two edges from fetch_addr to the outputs.
module branch_predictor_top (
  input  wire logic          clk,
  input  wire logic          reset,
  input  wire bp_pkg::addr_t fetch_addr,
  input  wire logic          update,
  input  wire bp_pkg::addr_t update_addr,
  input  wire bp_pkg::addr_t actual_target,
  input  wire logic          branch_taken,
  output logic               predict_taken,
  output logic               btb_hit,
  output bp_pkg::addr_t      next_pc
);

  // Lookup results, valid one edge after fetch_addr.
  logic          hit;
  logic          taken_hint;
  bp_pkg::addr_t target;

  // Resolution bus shared by both tables.
  bp_update_if upd ();

  assign upd.valid  = update;
  assign upd.addr   = update_addr;
  assign upd.target = actual_target;
  assign upd.taken  = branch_taken;

  branch_target_buffer u_btb (
    .clk        (clk),
    .reset      (reset),
    .fetch_addr (fetch_addr),
    .upd        (upd.sink),
    .hit        (hit),
    .target     (target)
  );

  direction_predictor u_dir (
    .clk        (clk),
    .reset      (reset),
    .fetch_addr (fetch_addr),
    .upd        (upd.sink),
    .taken_hint (taken_hint)
  );

  next_fetch_select u_sel (
    .clk           (clk),
    .reset         (reset),
    .fetch_addr    (fetch_addr),
    .hit           (hit),
    .taken_hint    (taken_hint),
    .target        (target),
    .predict_taken (predict_taken),
    .btb_hit       (btb_hit),
    .next_pc       (next_pc)
  );

endmodule

`default_nettype wire

// ==== hw/next_fetch_select.sv ====
`timescale 1ns/1ns
`default_nettype none

// Combines BTB hit and direction hint.
// Registers the prediction and next fetch address.
module next_fetch_select (
  input  wire logic          clk,
  input  wire logic          reset,
  input  wire bp_pkg::addr_t fetch_addr,
  input  wire logic          hit,
  input  wire logic          taken_hint,
  input  wire bp_pkg::addr_t target,
  output logic               predict_taken,
  output logic               btb_hit,
  output bp_pkg::addr_t      next_pc
);

  // Fetch address one edge late, lined up with the table reads.
  bp_pkg::addr_t fetch_addr_q;
  // Taken only when both structures agree.
  logic          taken_now;

  assign taken_now = hit && taken_hint;

  always_ff @(posedge clk) begin
    fetch_addr_q <= fetch_addr;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      predict_taken <= 1'b0;
      btb_hit       <= 1'b0;
      next_pc       <= '0;
    end else begin
      predict_taken <= taken_now;
      btb_hit       <= hit;
      // Stored target on a taken prediction, else fall through.
      if (taken_now) begin
        next_pc <= target;
      end else begin
        next_pc <= fetch_addr_q + 32'd4;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/direction_predictor.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_macros.svh"

// Table of 2-bit saturating counters, indexed like the BTB.
module direction_predictor (
  input  wire logic          clk,
  input  wire logic          reset,
  input  wire bp_pkg::addr_t fetch_addr,
  bp_update_if.sink          upd,
  output logic               taken_hint
);

  bp_pkg::index_t lookup_index;
  bp_pkg::index_t upd_index;

  // Registered lookup counter.
  bp_pkg::ctr_t   lookup_ctr;
  // Counter at the update index, and its next value.
  bp_pkg::ctr_t   upd_ctr;
  bp_pkg::ctr_t   ctr_next;

  assign lookup_index = fetch_addr[`BP_INDEX_BITS-1:0];
  assign upd_index    = upd.addr[`BP_INDEX_BITS-1:0];

  // Saturating step.
  // Up on taken, down on not taken, held at 0 and 3.
  always_comb begin
    ctr_next = upd_ctr;
    if (upd.taken) begin
      if (upd_ctr != 2'b11) begin
        ctr_next = upd_ctr + 2'd1;
      end
    end else begin
      if (upd_ctr != 2'b00) begin
        ctr_next = upd_ctr - 2'd1;
      end
    end
  end

  // Counters are always written valid.
  // Reset loads every counter with the weakly not taken value.
  direct_mapped_table #(
    .entry_t     (bp_pkg::ctr_t),
    .reset_entry (`BP_CTR_RESET)
  ) u_table (
    .clk        (clk),
    .reset      (reset),
    .rd_index   (lookup_index),
    .rd_valid   (),
    .rd_entry   (lookup_ctr),
    .wr_index   (upd_index),
    .wr_en      (upd.valid),
    .wr_valid   (1'b1),
    .wr_entry   (ctr_next),
    .peek_entry (upd_ctr)
  );

  // Upper bit is the direction.
  assign taken_hint = lookup_ctr[1];

endmodule

`default_nettype wire

// ==== hw/branch_target_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_macros.svh"

// Tagged direct-mapped BTB.
// Holds targets of branches last seen taken.
module branch_target_buffer (
  input  wire logic          clk,
  input  wire logic          reset,
  input  wire bp_pkg::addr_t fetch_addr,
  bp_update_if.sink          upd,
  output logic               hit,
  output bp_pkg::addr_t      target
);

  // Lookup side split.
  bp_pkg::index_t     lookup_index;
  bp_pkg::tag_t       lookup_tag;
  // Tag registered next to the table read.
  bp_pkg::tag_t       lookup_tag_q;

  // Table outputs.
  logic               entry_valid;
  bp_pkg::btb_entry_t entry;

  // Update side.
  bp_pkg::index_t     upd_index;
  bp_pkg::btb_entry_t upd_entry;

  assign lookup_index = fetch_addr[`BP_INDEX_BITS-1:0];
  assign lookup_tag   = fetch_addr[`BP_ADDR_BITS-1:`BP_INDEX_BITS];

  assign upd_index        = upd.addr[`BP_INDEX_BITS-1:0];
  assign upd_entry.tag    = upd.addr[`BP_ADDR_BITS-1:`BP_INDEX_BITS];
  assign upd_entry.target = upd.target;

  // Payload pipeline register, no reset.
  always_ff @(posedge clk) begin
    lookup_tag_q <= lookup_tag;
  end

  // Taken writes a valid entry, not taken invalidates it.
  direct_mapped_table #(
    .entry_t     (bp_pkg::btb_entry_t),
    .reset_entry ('0)
  ) u_table (
    .clk        (clk),
    .reset      (reset),
    .rd_index   (lookup_index),
    .rd_valid   (entry_valid),
    .rd_entry   (entry),
    .wr_index   (upd_index),
    .wr_en      (upd.valid),
    .wr_valid   (upd.taken),
    .wr_entry   (upd_entry),
    .peek_entry ()
  );

  // Hit needs a valid entry and a matching tag.
  assign hit    = entry_valid && (entry.tag == lookup_tag_q);
  // Target is zero on a miss.
  assign target = hit ? entry.target : '0;

endmodule

`default_nettype wire

// ==== hw/direct_mapped_table.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_macros.svh"

// Direct-mapped storage with one valid bit per entry.
// Lookup read is registered, the update side has a combinational peek.
module direct_mapped_table #(
  parameter type    entry_t     = logic,
  parameter entry_t reset_entry = '0
) (
  input  wire logic           clk,
  input  wire logic           reset,
  input  wire bp_pkg::index_t rd_index,
  output logic                rd_valid,
  output entry_t              rd_entry,
  input  wire bp_pkg::index_t wr_index,
  input  wire logic           wr_en,
  input  wire logic           wr_valid,
  input  wire entry_t         wr_entry,
  output entry_t              peek_entry
);

  localparam int entries = 1 << `BP_INDEX_BITS;

  // Per-entry state.
  logic   valid_q   [entries];
  entry_t payload_q [entries];

  // Current contents at the update index.
  // Lets a read-modify-write see the last update right away.
  assign peek_entry = payload_q[wr_index];

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
      rd_entry <= reset_entry;
      // All entries invalid, payloads back to their reset value.
      for (int i = 0; i < entries; i++) begin
        valid_q[i]   <= 1'b0;
        payload_q[i] <= reset_entry;
      end
    end else begin
      // Lookup samples the old contents.
      // A write at the same edge shows up one cycle later.
      rd_valid <= valid_q[rd_index];
      rd_entry <= payload_q[rd_index];
      if (wr_en) begin
        valid_q[wr_index] <= wr_valid;
        // Invalidate leaves the payload as it was.
        if (wr_valid) begin
          payload_q[wr_index] <= wr_entry;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/bp_update_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Branch resolution bus.
// One resolved branch per cycle with valid high, no handshake.
interface bp_update_if;

  // Update strobe.
  logic           valid;
  // Address of the resolved branch.
  bp_pkg::addr_t  addr;
  // Resolved target address.
  bp_pkg::addr_t  target;
  // Actual outcome, 1 when taken.
  logic           taken;

  // Driven by the top level from its ports.
  modport source (
    output valid,
    output addr,
    output target,
    output taken
  );

  // Read by the BTB and the direction predictor.
  modport sink (
    input valid,
    input addr,
    input target,
    input taken
  );

endinterface

`default_nettype wire

// ==== hw/bp_pkg.sv ====
`default_nettype none

`include "bp_macros.svh"

package bp_pkg;

  // One instruction address.
  typedef logic [`BP_ADDR_BITS-1:0] addr_t;

  // Table index, taken from the low address bits.
  typedef logic [`BP_INDEX_BITS-1:0] index_t;

  // BTB tag, the address bits above the index.
  typedef logic [`BP_ADDR_BITS-`BP_INDEX_BITS-1:0] tag_t;

  // One BTB payload.
  // Tag in the upper bits, target in the lower bits.
  typedef struct packed {
    tag_t  tag;
    addr_t target;
  } btb_entry_t;

  // Two-bit saturating direction counter.
  // Upper bit set means predict taken.
  typedef logic [1:0] ctr_t;

endpackage

`default_nettype wire

// ==== include/bp_macros.svh ====
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// Width of one instruction address in bits.
`define BP_ADDR_BITS 32

// Low address bits used as the table index.
// Eight bits give 256 entries per table.
`define BP_INDEX_BITS 8

// Counter value after reset.
// Weakly not taken, so one taken update flips the prediction.
`define BP_CTR_RESET 2'b01

`endif
